// File: dv/ntt_cases.txt
// ctl mode acc u00 u01 v00 v01 w00 w01 u10 v10 u11 v11 w10 w11 e0 e1 e2 e3 (hex)
// ctl 0 gap, 1 back-to-back, 2 dropped by zeroize; e0..e3 = u20 v20 u21 v21 or pw0..pw3
0 0 0 1 4 2 5 3 6 0 0 0 0 2 3 4B 7FDFC4 7FDFAE 49
0 0 0 7FE000 7FE000 7FE000 1 7FE000 1 0 0 0 0 7FE000 2 0 0 7FDFFB 2
// Streaming, eight ct sets back to back
0 0 0 1 0 1 0 1 0 0 0 0 0 0 0 2 2 0 0
1 0 0 2 0 1 0 1 0 0 0 0 0 0 0 3 3 1 1
1 0 0 3 0 1 0 1 0 0 0 0 0 0 0 4 4 2 2
1 0 0 4 0 1 0 1 0 0 0 0 0 0 0 5 5 3 3
1 0 0 5 0 1 0 1 0 0 0 0 0 0 0 6 6 4 4
1 0 0 6 0 1 0 1 0 0 0 0 0 0 0 7 7 5 5
1 0 0 7 0 1 0 1 0 0 0 0 0 0 0 8 8 6 6
1 0 0 8 0 1 0 1 0 0 0 0 0 0 0 9 9 7 7
// Zeroize drops these, then a normal case follows
2 0 0 11 22 33 44 55 66 0 0 0 0 77 88 0 0 0 0
2 0 0 5 6 7 8 9 A 0 0 0 0 B C 0 0 0 0
0 0 0 1 4 2 5 3 6 0 0 0 0 2 3 4B 7FDFC4 7FDFAE 49
// Inverse butterflies
0 1 0 A 5 3 9 2 4 0 0 0 0 3 7FE000 1B 7FDFFE 7FDFFF 7FDFE3
0 1 0 7FE000 1 7FE000 7FE000 7 5 0 0 0 0 9 7FE000 7FDFFF 7FDFEF A A
// Pointwise multiply, plain then accumulate
0 2 0 3 7FE000 4 7FE000 9 0 3E8 3E8 7FE000 2 0 0 C 1 F4240 7FDFFF
0 2 1 3 7FE000 4 7FE000 9 7FE000 5 6 1000 1000 7 1 15 0 25 3FFF
2 2 1 3 3 3 3 3 3 3 3 3 3 3 3 0 0 0 0
// Pointwise add and subtract
0 3 0 1 7FE000 2 1 0 0 7FE000 7FE000 100000 200000 0 0 3 0 7FDFFF 300000
0 4 0 5 0 3 1 0 0 3 7FE000 300000 100000 0 0 2 7FE000 4 200000

// File: compile.f
logic/ntt_pkg.sv
logic/ntt_mod_mult.sv
logic/ntt_butterfly.sv
logic/ntt_butterfly_2x2.sv
dv/ntt_butterfly_2x2_asserts.sv
dv/ntt_checker.sv
dv/tb_ntt_butterfly_2x2.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_ntt_butterfly_2x2
FILELIST  := compile.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log
RUN_ARGS  := +verilator+error+limit+1000
FAIL_MSG  := Some tests failed
PASS_MSG  := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation FAILED, no verdict in log"; exit 1; \
	fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_ntt_butterfly_2x2.sv
/*
 * Testbench top for the 2x2 NTT butterfly.
 * Reads cases from dv/ntt_cases.txt, drives them on falling edges and
 * hands expected results to the checker. Prints the final verdict.
 */

`timescale 1ns/1ps

module tb_ntt_butterfly_2x2
    import ntt_pkg::*;
();

    localparam int MAX_CASES = 64;
    localparam int FIELDS    = 19;
    localparam int FLUSH     = 8;

    logic   clk = 1'b0;
    logic   reset_n;
    logic   zeroize;
    logic   enable;
    logic   accumulate;
    mode_t  mode;
    coeff_t u00, u01, v00, v01, w00, w01, u10, v10, u11, v11, w10, w11;
    coeff_t u20, v20, u21, v21, pw0, pw1, pw2, pw3;
    logic   ready;

    // Checker side
    logic   push;
    mode_t  exp_mode;
    coeff_t exp0, exp1, exp2, exp3;
    logic   done;
    int     chk_pass;
    int     chk_fail;

    logic [31:0] case_mem [0:MAX_CASES*FIELDS-1];
    int          num_cases = 0;
    int          watchdog_cycles = 0;

    always #4 clk = ~clk;

    ntt_butterfly_2x2 DUT (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize), .enable_i(enable),
        .accumulate_i(accumulate), .mode_i(mode),
        .u00_i(u00), .u01_i(u01), .v00_i(v00), .v01_i(v01), .w00_i(w00), .w01_i(w01),
        .u10_i(u10), .v10_i(v10), .u11_i(u11), .v11_i(v11), .w10_i(w10), .w11_i(w11),
        .u20_o(u20), .v20_o(v20), .u21_o(u21), .v21_o(v21),
        .pw0_o(pw0), .pw1_o(pw1), .pw2_o(pw2), .pw3_o(pw3), .ready_o(ready)
    );

    ntt_checker chk_inst (
        .clk(clk), .reset_n(reset_n), .ready_i(ready),
        .u20_i(u20), .v20_i(v20), .u21_i(u21), .v21_i(v21),
        .pw0_i(pw0), .pw1_i(pw1), .pw2_i(pw2), .pw3_i(pw3),
        .push_i(push), .exp_mode_i(exp_mode),
        .exp0_i(exp0), .exp1_i(exp1), .exp2_i(exp2), .exp3_i(exp3),
        .done_i(done), .pass_count_o(chk_pass), .fail_count_o(chk_fail)
    );

    bind ntt_butterfly_2x2 ntt_butterfly_2x2_asserts asserts_inst (.*);

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------

    initial begin
        int    base;
        int    ctl;
        int    gap;
        int    total_fail;
        mode_t next_mode;
        logic  next_acc;
        {reset_n, zeroize, enable, accumulate, push, done} = '0;
        mode = ct;
        exp_mode = ct;
        {u00, u01, v00, v01, w00, w01, u10, v10, u11, v11, w10, w11} = '0;
        {exp0, exp1, exp2, exp3} = '0;
        void'($urandom(32'hec5f));

        for (int k = 0; k < MAX_CASES * FIELDS; k++) begin
            case_mem[k] = 32'hffff_ffff;
        end
        $readmemh("dv/ntt_cases.txt", case_mem);
        while (num_cases < MAX_CASES && case_mem[num_cases * FIELDS] != 32'hffff_ffff) begin
            num_cases++;
        end
        if (num_cases == 0) begin
            $display("No cases could be read from the case file");
            $display("Some tests failed");
            $finish;
        end
        watchdog_cycles = num_cases * 20 + 100;

        mode = mode_t'(case_mem[1][2:0]);
        accumulate = case_mem[2][0];
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        for (int i = 0; i < num_cases; i++) begin
            base      = i * FIELDS;
            ctl       = int'(case_mem[base]);
            next_mode = mode_t'(case_mem[base+1][2:0]);
            next_acc  = case_mem[base+2][0];
            // Mode must stay put while sets are in flight
            if (ctl == 2 || next_mode != mode || next_acc != accumulate) begin
                enable = 1'b0;
                repeat (FLUSH) @(negedge clk);
                mode       = next_mode;
                accumulate = next_acc;
            end
            else if (ctl == 0) begin
                enable = 1'b0;
                gap = int'($urandom % 32'd4);
                repeat (gap) @(negedge clk);
            end
            u00 = case_mem[base+3][COEFF_W-1:0];
            u01 = case_mem[base+4][COEFF_W-1:0];
            v00 = case_mem[base+5][COEFF_W-1:0];
            v01 = case_mem[base+6][COEFF_W-1:0];
            w00 = case_mem[base+7][COEFF_W-1:0];
            w01 = case_mem[base+8][COEFF_W-1:0];
            u10 = case_mem[base+9][COEFF_W-1:0];
            v10 = case_mem[base+10][COEFF_W-1:0];
            u11 = case_mem[base+11][COEFF_W-1:0];
            v11 = case_mem[base+12][COEFF_W-1:0];
            w10 = case_mem[base+13][COEFF_W-1:0];
            w11 = case_mem[base+14][COEFF_W-1:0];
            exp_mode = next_mode;
            exp0 = case_mem[base+15][COEFF_W-1:0];
            exp1 = case_mem[base+16][COEFF_W-1:0];
            exp2 = case_mem[base+17][COEFF_W-1:0];
            exp3 = case_mem[base+18][COEFF_W-1:0];
            enable = 1'b1;
            push   = (ctl != 2);
            @(negedge clk);
            push = 1'b0;
            if (ctl == 2) begin
                // Drop the set while it is still inside layer 1
                enable = 1'b0;
                @(negedge clk);
                zeroize = 1'b1;
                @(negedge clk);
                zeroize = 1'b0;
            end
        end

        enable = 1'b0;
        repeat (12) @(negedge clk);
        done = 1'b1;
        repeat (2) @(negedge clk);

        total_fail = chk_fail + DUT.asserts_inst.fail_count;
        $display("Results: %0d passed, %0d failed, %0d assertion failures",
                 chk_pass, chk_fail, DUT.asserts_inst.fail_count);
        if (total_fail == 0) begin
            $display("All tests passed");
        end
        else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog sized from the number of cases
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the run did not finish", watchdog_cycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: dv/ntt_checker.sv
/*
 * Result checker for the 2x2 butterfly.
 * Queues expected results pushed by the testbench and compares them in
 * order against the DUT outputs on every ready_o pulse.
 */

`timescale 1ns/1ps

module ntt_checker
    import ntt_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  logic   ready_i,
    input  coeff_t u20_i,
    input  coeff_t v20_i,
    input  coeff_t u21_i,
    input  coeff_t v21_i,
    input  coeff_t pw0_i,
    input  coeff_t pw1_i,
    input  coeff_t pw2_i,
    input  coeff_t pw3_i,
    input  logic   push_i,
    input  mode_t  exp_mode_i,
    input  coeff_t exp0_i,
    input  coeff_t exp1_i,
    input  coeff_t exp2_i,
    input  coeff_t exp3_i,
    input  logic   done_i,
    output int     pass_count_o,
    output int     fail_count_o
);

    mode_t  mode_q[$];
    coeff_t e0_q[$];
    coeff_t e1_q[$];
    coeff_t e2_q[$];
    coeff_t e3_q[$];
    int     id_q[$];
    int     next_id = 0;
    logic   done_seen = 1'b0;

    function automatic bit value_ok(input string name, input coeff_t exp_val,
                                    input coeff_t act_val);
        if (exp_val !== act_val) begin
            $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, exp_val, act_val);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    always @(posedge clk) begin
        mode_t  m;
        coeff_t e0;
        coeff_t e1;
        coeff_t e2;
        coeff_t e3;
        int     id;
        bit     ok;
        if (!reset_n) begin
            pass_count_o <= 0;
            fail_count_o <= 0;
        end
        else begin
            if (push_i) begin
                mode_q.push_back(exp_mode_i);
                e0_q.push_back(exp0_i);
                e1_q.push_back(exp1_i);
                e2_q.push_back(exp2_i);
                e3_q.push_back(exp3_i);
                id_q.push_back(next_id);
                next_id = next_id + 1;
            end
            if (ready_i && mode_q.size() == 0) begin
                $display("ERROR at %0d ns: unexpected ready pulse with no result pending", $time);
                fail_count_o <= fail_count_o + 1;
            end
            else if (ready_i) begin
                m  = mode_q.pop_front();
                e0 = e0_q.pop_front();
                e1 = e1_q.pop_front();
                e2 = e2_q.pop_front();
                e3 = e3_q.pop_front();
                id = id_q.pop_front();
                ok = 1'b1;
                // Transform modes use the layer 2 outputs, the rest the lanes
                if (m == ct || m == gs) begin
                    ok = value_ok("u20_o", e0, u20_i) & ok;
                    ok = value_ok("v20_o", e1, v20_i) & ok;
                    ok = value_ok("u21_o", e2, u21_i) & ok;
                    ok = value_ok("v21_o", e3, v21_i) & ok;
                end
                else begin
                    ok = value_ok("pw0_o", e0, pw0_i) & ok;
                    ok = value_ok("pw1_o", e1, pw1_i) & ok;
                    ok = value_ok("pw2_o", e2, pw2_i) & ok;
                    ok = value_ok("pw3_o", e3, pw3_i) & ok;
                end
                if (ok) begin
                    $display("PASS test %0d (%s) at %0d ns", id, m.name(), $time);
                    pass_count_o <= pass_count_o + 1;
                end
                else begin
                    $display("Test %0d (%s) had wrong outputs", id, m.name());
                    fail_count_o <= fail_count_o + 1;
                end
            end
            // Anything still queued at the end never came out of the DUT
            if (done_i && !done_seen) begin
                done_seen = 1'b1;
                foreach (id_q[k]) begin
                    $display("ERROR: result for test %0d never arrived", id_q[k]);
                end
                fail_count_o <= fail_count_o + id_q.size();
            end
        end
    end

endmodule

// File: dv/ntt_butterfly_2x2_asserts.sv
/*
 * Concurrent assertions for the 2x2 butterfly top level.
 * Bound into the DUT from the testbench top.
 */

`timescale 1ns/1ps

module ntt_butterfly_2x2_asserts
    import ntt_pkg::*;
(
    input logic   clk,
    input logic   reset_n,
    input logic   enable_i,
    input mode_t  mode_i,
    input logic   ready_o,
    input coeff_t u20_o,
    input coeff_t v20_o,
    input coeff_t u21_o,
    input coeff_t v21_o,
    input coeff_t pw0_o,
    input coeff_t pw1_o,
    input coeff_t pw2_o,
    input coeff_t pw3_o
);

    // Failed assertions, read by the testbench summary
    int fail_count = 0;

    logic pw_mode;

    assign pw_mode = (mode_i inside {pwm, pwa, pws});

    a_ready_known: assert property (@(posedge clk) disable iff (!reset_n)
        !$isunknown(ready_o))
    else begin
        fail_count++;
        $error("ready_o is unknown");
    end

    // Ready must trace back to an enable one or two butterflies earlier
    a_ready_latency: assert property (@(posedge clk) disable iff (!reset_n)
        ready_o |-> (pw_mode ? $past(enable_i, 4) : $past(enable_i, 8)))
    else begin
        fail_count++;
        $error("ready_o without a matching enable_i");
    end

    a_nt_range: assert property (@(posedge clk) disable iff (!reset_n)
        (ready_o && !pw_mode) |->
            (u20_o < NTT_Q && v20_o < NTT_Q && u21_o < NTT_Q && v21_o < NTT_Q))
    else begin
        fail_count++;
        $error("transform output not reduced below q");
    end

    a_pw_range: assert property (@(posedge clk) disable iff (!reset_n)
        (ready_o && pw_mode) |->
            (pw0_o < NTT_Q && pw1_o < NTT_Q && pw2_o < NTT_Q && pw3_o < NTT_Q))
    else begin
        fail_count++;
        $error("lane output not reduced below q");
    end

endmodule

// File: logic/ntt_butterfly_2x2.sv
/*
 * Top level of the 2x2 NTT butterfly unit.
 * ct and gs pass one input set through two butterfly layers; the
 * pointwise modes run the four butterflies as independent lanes.
 * enable_i marks an input set, ready_o marks its results.
 */

`timescale 1ns/1ps

module ntt_butterfly_2x2
    import ntt_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,

    input  logic   zeroize_i,
    input  logic   enable_i,
    input  logic   accumulate_i,

    input  mode_t  mode_i,

    input  coeff_t u00_i,
    input  coeff_t u01_i,
    input  coeff_t v00_i,
    input  coeff_t v01_i,
    input  coeff_t w00_i,
    input  coeff_t w01_i,
    input  coeff_t u10_i,
    input  coeff_t v10_i,
    input  coeff_t u11_i,
    input  coeff_t v11_i,
    input  coeff_t w10_i,
    input  coeff_t w11_i,

    output coeff_t u20_o,
    output coeff_t v20_o,
    output coeff_t u21_o,
    output coeff_t v21_o,
    output coeff_t pw0_o,
    output coeff_t pw1_o,
    output coeff_t pw2_o,
    output coeff_t pw3_o,

    output logic   ready_o
);

    // Enable travels through both layers in ct and gs
    localparam int READY_DEPTH = 2 * BF_LATENCY;

    logic pwo_mode;

    // Layer 1 results
    coeff_t u10_int;
    coeff_t u11_int;
    coeff_t v10_int;
    coeff_t v11_int;

    // Layer 2 operands after the input mux
    coeff_t u10;
    coeff_t v10;
    coeff_t w10;
    coeff_t u11;
    coeff_t v11;
    coeff_t w11;

    // Second-layer twiddles waiting for layer 1
    coeff_t [BF_LATENCY-1:0] w10_dly;
    coeff_t [BF_LATENCY-1:0] w11_dly;

    // Enable history, bit k set means enable_i was high k+1 cycles ago
    logic [READY_DEPTH-1:0] enable_sr;

    assign pwo_mode = (mode_i inside {pwm, pwa, pws});

    // ------------------------------------------------------------------
    // Twiddle delay and enable history
    // ------------------------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            w10_dly   <= '0;
            w11_dly   <= '0;
            enable_sr <= '0;
        end
        else if (zeroize_i) begin
            w10_dly   <= '0;
            w11_dly   <= '0;
            enable_sr <= '0;
        end
        else begin
            w10_dly   <= {w10_dly[BF_LATENCY-2:0], w10_i};
            w11_dly   <= {w11_dly[BF_LATENCY-2:0], w11_i};
            enable_sr <= {enable_sr[READY_DEPTH-2:0], enable_i};
        end
    end

    // ------------------------------------------------------------------
    // Layer 2 input mux
    // ------------------------------------------------------------------

    always_comb begin
        if (pwo_mode) begin
            // Lanes 2 and 3 take their operands straight from the ports
            u10 = u10_i;
            v10 = v10_i;
            w10 = w10_i;
            u11 = u11_i;
            v11 = v11_i;
            w11 = w11_i;
        end
        else begin
            u10 = u10_int;
            v10 = v10_int;
            w10 = w10_dly[BF_LATENCY-1];
            u11 = u11_int;
            v11 = v11_int;
            w11 = w11_dly[BF_LATENCY-1];
        end
    end

    // ------------------------------------------------------------------
    // Layer 1, also lanes 0 and 1
    // ------------------------------------------------------------------

    ntt_butterfly bf_inst00 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .accumulate_i (accumulate_i),
        .mode_i       (mode_i),
        .u_i          (u00_i),
        .v_i          (v00_i),
        .w_i          (w00_i),
        .u_o          (u10_int),
        .v_o          (u11_int),
        .pw_o         (pw0_o)
    );

    ntt_butterfly bf_inst01 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .accumulate_i (accumulate_i),
        .mode_i       (mode_i),
        .u_i          (u01_i),
        .v_i          (v01_i),
        .w_i          (w01_i),
        .u_o          (v10_int),
        .v_o          (v11_int),
        .pw_o         (pw1_o)
    );

    // ------------------------------------------------------------------
    // Layer 2, also lanes 2 and 3
    // ------------------------------------------------------------------

    ntt_butterfly bf_inst10 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .accumulate_i (accumulate_i),
        .mode_i       (mode_i),
        .u_i          (u10),
        .v_i          (v10),
        .w_i          (w10),
        .u_o          (u20_o),
        .v_o          (v20_o),
        .pw_o         (pw2_o)
    );

    ntt_butterfly bf_inst11 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .accumulate_i (accumulate_i),
        .mode_i       (mode_i),
        .u_i          (u11),
        .v_i          (v11),
        .w_i          (w11),
        .u_o          (u21_o),
        .v_o          (v21_o),
        .pw_o         (pw3_o)
    );

    // One butterfly of latency in the pointwise modes, two otherwise
    assign ready_o = pwo_mode ? enable_sr[BF_LATENCY-1] : enable_sr[READY_DEPTH-1];

endmodule

// File: logic/ntt_butterfly.sv
/*
 * Configurable modular butterfly.
 * Performs a ct or gs butterfly, or one pwm, pwa or pws lane, selected
 * by mode_i. Every mode produces its result BF_LATENCY cycles after the
 * operands are presented.
 */

`timescale 1ns/1ps

module ntt_butterfly
    import ntt_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  logic   zeroize_i,
    input  logic   accumulate_i,

    input  mode_t  mode_i,
    input  coeff_t u_i,
    input  coeff_t v_i,
    input  coeff_t w_i,

    output coeff_t u_o,
    output coeff_t v_o,
    output coeff_t pw_o
);

    // Multiplier operands and result
    coeff_t mult_a;
    coeff_t mult_b;
    coeff_t prod;

    // Operands delayed to line up with the product
    coeff_t [MULT_LATENCY-1:0] u_dly;
    coeff_t [MULT_LATENCY-1:0] v_dly;
    coeff_t [MULT_LATENCY-1:0] w_dly;

    // Final stage next values and registers
    coeff_t u_nxt;
    coeff_t v_nxt;
    coeff_t pw_nxt;
    coeff_t u_q;
    coeff_t v_q;
    coeff_t pw_q;

    // ------------------------------------------------------------------
    // Modular add and subtract, both inputs already below q
    // ------------------------------------------------------------------

    function automatic coeff_t add_mod(input coeff_t a, input coeff_t b);
        logic [COEFF_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= {1'b0, NTT_Q}) begin
            sum = sum - {1'b0, NTT_Q};
        end
        return sum[COEFF_W-1:0];
    endfunction

    function automatic coeff_t sub_mod(input coeff_t a, input coeff_t b);
        logic [COEFF_W:0] diff;
        diff = {1'b0, a} - {1'b0, b};
        // Wrap back into range when the difference went negative
        if (a < b) begin
            diff = diff + {1'b0, NTT_Q};
        end
        return diff[COEFF_W-1:0];
    endfunction

    // ------------------------------------------------------------------
    // Multiplier operand select
    // ------------------------------------------------------------------

    always_comb begin
        case (mode_i)
            ct: begin
                mult_a = v_i;
                mult_b = w_i;
            end
            // Difference is captured by the multiplier input register
            gs: begin
                mult_a = sub_mod(u_i, v_i);
                mult_b = w_i;
            end
            default: begin
                mult_a = u_i;
                mult_b = v_i;
            end
        endcase
    end

    ntt_mod_mult mult_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (mult_a),
        .b_i       (mult_b),
        .p_o       (prod)
    );

    // ------------------------------------------------------------------
    // Operand delay line, oldest entry at the top
    // ------------------------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            u_dly <= '0;
            v_dly <= '0;
            w_dly <= '0;
        end
        else if (zeroize_i) begin
            u_dly <= '0;
            v_dly <= '0;
            w_dly <= '0;
        end
        else begin
            u_dly <= {u_dly[MULT_LATENCY-2:0], u_i};
            v_dly <= {v_dly[MULT_LATENCY-2:0], v_i};
            w_dly <= {w_dly[MULT_LATENCY-2:0], w_i};
        end
    end

    // ------------------------------------------------------------------
    // Final add/sub stage
    // ------------------------------------------------------------------

    always_comb begin
        u_nxt  = add_mod(u_dly[MULT_LATENCY-1], prod);
        v_nxt  = sub_mod(u_dly[MULT_LATENCY-1], prod);
        pw_nxt = '0;
        case (mode_i)
            gs: begin
                u_nxt = add_mod(u_dly[MULT_LATENCY-1], v_dly[MULT_LATENCY-1]);
                v_nxt = prod;
            end
            pwm:     pw_nxt = accumulate_i ? add_mod(prod, w_dly[MULT_LATENCY-1]) : prod;
            pwa:     pw_nxt = add_mod(u_dly[MULT_LATENCY-1], v_dly[MULT_LATENCY-1]);
            pws:     pw_nxt = sub_mod(u_dly[MULT_LATENCY-1], v_dly[MULT_LATENCY-1]);
            default: pw_nxt = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            u_q  <= '0;
            v_q  <= '0;
            pw_q <= '0;
        end
        else if (zeroize_i) begin
            u_q  <= '0;
            v_q  <= '0;
            pw_q <= '0;
        end
        else begin
            u_q  <= u_nxt;
            v_q  <= v_nxt;
            pw_q <= pw_nxt;
        end
    end

    assign u_o  = u_q;
    assign v_o  = v_q;
    assign pw_o = pw_q;

endmodule

// File: logic/ntt_mod_mult.sv
/*
 * Pipelined modular multiplier for coefficients modulo q.
 * Accepts a new operand pair every cycle; the reduced product leaves
 * MULT_LATENCY cycles after the operands are sampled.
 */

`timescale 1ns/1ps

module ntt_mod_mult
    import ntt_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  logic   zeroize_i,

    input  coeff_t a_i,
    input  coeff_t b_i,

    output coeff_t p_o
);

    // Stage 1 operands
    coeff_t a_q;
    coeff_t b_q;

    // Stage 2 unreduced product
    prod_t  prod_q;

    // Stage 3 reduced result
    coeff_t p_q;

    // ------------------------------------------------------------------
    // Three register stages
    // ------------------------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            a_q    <= '0;
            b_q    <= '0;
            prod_q <= '0;
            p_q    <= '0;
        end
        else if (zeroize_i) begin
            a_q    <= '0;
            b_q    <= '0;
            prod_q <= '0;
            p_q    <= '0;
        end
        else begin
            a_q    <= a_i;
            b_q    <= b_i;
            // Full 46-bit product, both factors below q
            prod_q <= prod_t'(a_q) * prod_t'(b_q);
            // Remainder is below q so it fits one coefficient
            p_q    <= coeff_t'(prod_q % prod_t'(NTT_Q));
        end
    end

    assign p_o = p_q;

endmodule

// File: logic/ntt_pkg.sv
/*
 * Shared definitions for the NTT butterfly datapath.
 * Holds the field modulus, coefficient types, the operating modes and the
 * pipeline latencies. Modules pull these in with a wildcard import.
 */

package ntt_pkg;

    // ------------------------------------------------------------------
    // Field and coefficient widths
    // ------------------------------------------------------------------

    // Bits in one reduced coefficient
    localparam int COEFF_W = 23;

    // Coefficient reduced modulo q
    typedef logic [COEFF_W-1:0] coeff_t;

    // Full product of two coefficients before reduction
    typedef logic [2*COEFF_W-1:0] prod_t;

    // Prime modulus q = 2^23 - 2^13 + 1
    localparam coeff_t NTT_Q = 23'd8380417;

    // ------------------------------------------------------------------
    // Operating modes
    // ------------------------------------------------------------------

    // ct and gs run the two-layer transform, the rest use four lanes
    typedef enum logic [2:0] {
        ct  = 3'd0,
        gs  = 3'd1,
        pwm = 3'd2,
        pwa = 3'd3,
        pws = 3'd4
    } mode_t;

    // ------------------------------------------------------------------
    // Pipeline latencies in clock cycles
    // ------------------------------------------------------------------

    // Operand register, product register, reduction register
    localparam int MULT_LATENCY = 3;

    // Multiplier plus the final add/sub register
    localparam int BF_LATENCY = 4;

endpackage
